//--- pi_ctrl_pkg.sv
package pi_ctrl_pkg;

    localparam int CHANNELS     = 2;
    localparam int DATA_WIDTH   = 16;
    localparam int GAIN_WIDTH   = 16;
    localparam int SCALE        = 16;  // fractional bits of kp, ki
    localparam int DATA_LIMIT   = 2960;
    localparam int INDEX_MAX    = 3 + 3 * CHANNELS;
    localparam int CALC_CYCLES  = INDEX_MAX + 1;
    localparam int PERIOD_WIDTH = 16;

    // core datapath widths
    localparam int ERR_WIDTH    = DATA_WIDTH + 1;
    localparam int DIFF_WIDTH   = DATA_WIDTH + 2;
    localparam int PROD_WIDTH   = DIFF_WIDTH + GAIN_WIDTH;
    localparam int ACC_WIDTH    = PROD_WIDTH + 2;
    localparam int SAT_WIDTH    = $clog2(DATA_LIMIT + 1) + 1 + SCALE;
    localparam int INDEX_WIDTH  = $clog2(INDEX_MAX + 1);
    localparam int SAT_MAX      = DATA_LIMIT * 2**SCALE;
    localparam int ROUND_HALF   = 2**(SCALE - 1);

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef logic [GAIN_WIDTH-1:0]        gain_t;
    typedef logic [7:0]                   apb_addr_t;
    typedef logic [31:0]                  apb_word_t;

    typedef enum apb_addr_t {
        REG_CTRL   = 8'h00,
        REG_PERIOD = 8'h04,
        REG_KP     = 8'h08,
        REG_KI     = 8'h0C,
        REG_REF0   = 8'h10,
        REG_REF1   = 8'h14,
        REG_OUT0   = 8'h18,  // read only
        REG_OUT1   = 8'h1C,  // read only
        REG_COUNT  = 8'h20   // read only
    } reg_addr_e;

    // rotating step of one channel
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ERROR,
        PH_DIFF,
        PH_GAIN
    } calc_phase_e;

endpackage

//--- pi_apb_regs.sv
module pi_apb_regs (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  psel,
    input  logic                                                  penable,
    input  logic                                                  pwrite,
    input  pi_ctrl_pkg::apb_addr_t                                paddr,
    input  pi_ctrl_pkg::apb_word_t                                pwdata,
    output pi_ctrl_pkg::apb_word_t                                prdata,
    output logic                                                  enable,
    output logic [pi_ctrl_pkg::PERIOD_WIDTH-1:0]                  period,
    output pi_ctrl_pkg::gain_t                                    kp,
    output pi_ctrl_pkg::gain_t                                    ki,
    output logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] ref_data,
    output logic                                                  ref_valid,
    input  logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] ctrl_data,
    input  logic                                                  ctrl_valid
);
    import pi_ctrl_pkg::*;

    logic                             wr_en;
    logic [CHANNELS*DATA_WIDTH-1:0]   out_q;
    apb_word_t                        update_count;

    // channel 0 sits in the upper lane
    function automatic sample_t lane(input logic [CHANNELS*DATA_WIDTH-1:0] v, input int c);
        return v[DATA_WIDTH*(CHANNELS-1-c) +: DATA_WIDTH];
    endfunction

    function automatic apb_word_t sign_extend(input sample_t s);
        return {{(32 - DATA_WIDTH){s[DATA_WIDTH-1]}}, s};
    endfunction

    assign wr_en = psel & penable & pwrite;  // access cycle only

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable    <= 1'b0;
            period    <= '0;
            kp        <= '0;
            ki        <= '0;
            ref_data  <= '0;
            ref_valid <= 1'b0;
        end else begin
            ref_valid <= wr_en && (paddr == REG_REF0 || paddr == REG_REF1);
            if (wr_en) begin
                case (paddr)
                    REG_CTRL:   enable <= pwdata[0];
                    REG_PERIOD: period <= pwdata[PERIOD_WIDTH-1:0];
                    REG_KP:     kp     <= pwdata[GAIN_WIDTH-1:0];
                    REG_KI:     ki     <= pwdata[GAIN_WIDTH-1:0];
                    REG_REF0: begin
                        ref_data[DATA_WIDTH*(CHANNELS-1) +: DATA_WIDTH] <= pwdata[DATA_WIDTH-1:0];
                    end
                    REG_REF1: begin
                        ref_data[DATA_WIDTH*(CHANNELS-2) +: DATA_WIDTH] <= pwdata[DATA_WIDTH-1:0];
                    end
                    default: ;  // read-only or unmapped
                endcase
            end
        end
    end

    // status capture from the core
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_q        <= '0;
            update_count <= '0;
        end else if (ctrl_valid) begin
            out_q        <= ctrl_data;
            update_count <= update_count + 32'd1;
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL:   prdata[0] = enable;
            REG_PERIOD: prdata[PERIOD_WIDTH-1:0] = period;
            REG_KP:     prdata[GAIN_WIDTH-1:0] = kp;
            REG_KI:     prdata[GAIN_WIDTH-1:0] = ki;
            REG_REF0:   prdata = sign_extend(lane(ref_data, 0));
            REG_REF1:   prdata = sign_extend(lane(ref_data, 1));
            REG_OUT0:   prdata = sign_extend(lane(out_q, 0));
            REG_OUT1:   prdata = sign_extend(lane(out_q, 1));
            REG_COUNT:  prdata = update_count;
            default:    prdata = '0;
        endcase
    end

endmodule

//--- pi_sample_timer.sv
module pi_sample_timer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 enable,
    input  logic [pi_ctrl_pkg::PERIOD_WIDTH-1:0] period,
    output logic                                 trigger
);
    import pi_ctrl_pkg::*;

    logic [PERIOD_WIDTH-1:0] count;

    // wraps at period, so one trigger every period + 1 cycles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            trigger <= 1'b0;
        end else if (!enable) begin
            count   <= '0;
            trigger <= 1'b0;
        end else if (count >= period) begin  // also catches a shortened period
            count   <= '0;
            trigger <= 1'b1;
        end else begin
            count   <= count + 1'b1;
            trigger <= 1'b0;
        end
    end

endmodule

//--- pi_controller.sv
module pi_controller (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic                                                     trigger,
    input  pi_ctrl_pkg::gain_t                                       kp,
    input  pi_ctrl_pkg::gain_t                                       ki,
    input  logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] ref_data,
    input  logic                                                     ref_valid,
    input  logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] proc_data,
    input  logic                                                     proc_valid,
    output logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] ctrl_data,
    output logic                                                     ctrl_valid
);
    import pi_ctrl_pkg::*;

    calc_phase_e                  phase;
    calc_phase_e                  next_phase;
    logic [INDEX_WIDTH-1:0]       index;
    int                           step;
    sample_t                      ref_q  [CHANNELS];
    sample_t                      proc_q [CHANNELS];
    logic signed [ERR_WIDTH-1:0]  err;
    logic signed [ERR_WIDTH-1:0]  err_prev [CHANNELS];
    logic signed [DIFF_WIDTH-1:0] diff;
    logic signed [DIFF_WIDTH-1:0] mul_a;
    logic signed [GAIN_WIDTH:0]   mul_b;
    logic signed [PROD_WIDTH-1:0] product;
    logic signed [ACC_WIDTH-1:0]  acc;
    logic signed [SAT_WIDTH-1:0]  u_prev [CHANNELS];
    logic signed [SAT_WIDTH-1:0]  sat_val;
    logic signed [ACC_WIDTH-1:0]  round_val;
    sample_t                      u_round;

    assign step = int'(index);

    always_comb begin
        case (phase)
            PH_ERROR: next_phase = PH_DIFF;
            PH_DIFF:  next_phase = PH_GAIN;
            PH_GAIN:  next_phase = PH_ERROR;
            default:  next_phase = PH_IDLE;
        endcase
    end

    // step sequencer, triggers while busy are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= PH_IDLE;
            index      <= '0;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= (step == INDEX_MAX);
            if (phase == PH_IDLE) begin
                if (trigger) begin
                    phase <= PH_ERROR;
                    index <= INDEX_WIDTH'(1);
                end
            end else if (step == INDEX_MAX) begin
                phase <= PH_IDLE;
                index <= '0;
            end else begin
                phase <= next_phase;
                index <= index + 1'b1;
            end
        end
    end

    // input latches
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int c = 0; c < CHANNELS; c++) begin
                ref_q[c]  <= '0;
                proc_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (ref_valid)
                    ref_q[c] <= ref_data[DATA_WIDTH*(CHANNELS-1-c) +: DATA_WIDTH];
                if (proc_valid)
                    proc_q[c] <= proc_data[DATA_WIDTH*(CHANNELS-1-c) +: DATA_WIDTH];
            end
        end
    end

    // error at step 1+3c, difference at step 2+3c
    always_ff @(posedge clk) begin
        for (int c = 0; c < CHANNELS; c++) begin
            if (phase == PH_ERROR && step == 1 + 3 * c)
                err <= ref_q[c] - proc_q[c];
            if (phase == PH_DIFF && step == 2 + 3 * c)
                diff <= err - err_prev[c];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int c = 0; c < CHANNELS; c++)
                err_prev[c] <= '0;
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (phase == PH_DIFF && step == 2 + 3 * c)
                    err_prev[c] <= err;
            end
        end
    end

    // shared multiplier, ki*e then kp*d
    always_ff @(posedge clk) begin
        if (phase == PH_DIFF) begin
            mul_a <= err;
            mul_b <= {1'b0, ki};
        end else if (phase == PH_GAIN) begin
            mul_a <= diff;
            mul_b <= {1'b0, kp};
        end
        product <= mul_a * mul_b;
    end

    // acc = u_prev + ki*e + kp*d in Q.SCALE
    always_ff @(posedge clk) begin
        if (phase == PH_GAIN && step <= 3 * CHANNELS) begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (step == 3 + 3 * c)
                    acc <= u_prev[c];
            end
        end else if ((phase == PH_ERROR || phase == PH_DIFF) && step > 3) begin
            acc <= acc + product;
        end
    end

    always_comb begin
        if (acc > ACC_WIDTH'(SAT_MAX))
            sat_val = SAT_WIDTH'(SAT_MAX);
        else if (acc < ACC_WIDTH'(-SAT_MAX))
            sat_val = SAT_WIDTH'(-SAT_MAX);
        else
            sat_val = acc[SAT_WIDTH-1:0];
        round_val = ACC_WIDTH'(sat_val) + ACC_WIDTH'(ROUND_HALF);  // round half up
        u_round   = sample_t'(round_val >>> SCALE);
    end

    // u_prev keeps the clamped value, not the rounded one
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_data <= '0;
            for (int c = 0; c < CHANNELS; c++)
                u_prev[c] <= '0;
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (step == 6 + 3 * c) begin
                    ctrl_data[DATA_WIDTH*(CHANNELS-1-c) +: DATA_WIDTH] <= u_round;
                    u_prev[c] <= sat_val;
                end
            end
        end
    end

endmodule

//--- pi_ctrl_top.sv
module pi_ctrl_top (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic                                                     psel,
    input  logic                                                     penable,
    input  logic                                                     pwrite,
    input  pi_ctrl_pkg::apb_addr_t                                   paddr,
    input  pi_ctrl_pkg::apb_word_t                                   pwdata,
    output pi_ctrl_pkg::apb_word_t                                   prdata,
    input  logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] sensor_data,
    input  logic                                                     sensor_valid,
    output logic [pi_ctrl_pkg::CHANNELS*pi_ctrl_pkg::DATA_WIDTH-1:0] ctrl_data,
    output logic                                                     ctrl_valid
);
    import pi_ctrl_pkg::*;

    logic                           enable;
    logic [PERIOD_WIDTH-1:0]        period;
    gain_t                          kp;
    gain_t                          ki;
    logic [CHANNELS*DATA_WIDTH-1:0] ref_data;
    logic                           ref_valid;
    logic                           trigger;

    pi_apb_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .enable     (enable),
        .period     (period),
        .kp         (kp),
        .ki         (ki),
        .ref_data   (ref_data),
        .ref_valid  (ref_valid),
        .ctrl_data  (ctrl_data),
        .ctrl_valid (ctrl_valid)
    );

    pi_sample_timer u_timer (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .period  (period),
        .trigger (trigger)
    );

    // sensor front end feeds the core directly
    pi_controller u_core (
        .clk        (clk),
        .reset      (reset),
        .trigger    (trigger),
        .kp         (kp),
        .ki         (ki),
        .ref_data   (ref_data),
        .ref_valid  (ref_valid),
        .proc_data  (sensor_data),
        .proc_valid (sensor_valid),
        .ctrl_data  (ctrl_data),
        .ctrl_valid (ctrl_valid)
    );

endmodule

//--- tb_pi_ctrl_top.sv
module tb_pi_ctrl_top;
    timeunit 1ns;
    timeprecision 100ps;

    import pi_ctrl_pkg::*;

    logic                           clk;
    logic                           reset;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    apb_addr_t                      paddr;
    apb_word_t                      pwdata;
    apb_word_t                      prdata;
    logic [CHANNELS*DATA_WIDTH-1:0] sensor_data;
    logic                           sensor_valid;
    logic [CHANNELS*DATA_WIDTH-1:0] ctrl_data;
    logic                           ctrl_valid;

    int      pass_count;
    int      fail_count;
    int      fails_before_test;
    int      update_total;
    int      period_m;
    longint  kp_m;
    longint  ki_m;
    longint  ref_m    [CHANNELS];
    longint  sens_m   [CHANNELS];
    longint  e_prev_m [CHANNELS];
    longint  u_prev_m [CHANNELS];
    sample_t u_exp    [CHANNELS];
    sample_t last_out [CHANNELS];

    pi_ctrl_top UUT (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .sensor_data  (sensor_data),
        .sensor_valid (sensor_valid),
        .ctrl_data    (ctrl_data),
        .ctrl_valid   (ctrl_valid)
    );

    always #10 clk = ~clk;

    task automatic apb_write(input apb_addr_t addr, input apb_word_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);  // write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_word_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data    = prdata;  // access cycle value
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (expected === actual) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input apb_word_t expected,
                              input apb_word_t actual);
        if (expected === actual) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        fail_count++;
        $display("%s", msg);
    endtask

    task automatic test_done(input string name);
        $display("test %-14s finished with %0d errors", name, fail_count - fails_before_test);
        fails_before_test = fail_count;
    endtask

    function automatic sample_t random_sample(input int span);
        return sample_t'(int'($urandom_range(2 * span, 0)) - span);
    endfunction

    function automatic sample_t ctrl_channel(input int c);
        return sample_t'(ctrl_data[DATA_WIDTH*(CHANNELS-1-c) +: DATA_WIDTH]);
    endfunction

    // velocity form, u_prev kept clamped, round half up
    task automatic model_update();
        longint e;
        longint d;
        longint acc;
        longint lim;
        lim = longint'(DATA_LIMIT) <<< SCALE;
        for (int c = 0; c < CHANNELS; c++) begin
            e   = ref_m[c] - sens_m[c];
            d   = e - e_prev_m[c];
            acc = u_prev_m[c] + ki_m * e + kp_m * d;
            if (acc > lim)
                acc = lim;
            else if (acc < -lim)
                acc = -lim;
            e_prev_m[c] = e;
            u_prev_m[c] = acc;
            u_exp[c]    = sample_t'((acc + (longint'(1) <<< (SCALE - 1))) >>> SCALE);
        end
    endtask

    task automatic set_sensors(input sample_t s0, input sample_t s1);
        sens_m[0]    = s0;
        sens_m[1]    = s1;
        sensor_data  <= {s0, s1};  // channel 0 in the upper half
        sensor_valid <= 1'b1;
        @(posedge clk);
        sensor_valid <= 1'b0;
    endtask

    task automatic wait_for_update(input string name, output bit seen);
        int limit;
        int n;
        limit = 2 * (period_m + 1) + CALC_CYCLES + 8;
        seen  = 1'b0;
        n     = 0;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = ctrl_valid;
            n++;
        end
        if (!seen)
            note_failure($sformatf("timeout: no ctrl_valid within %0d cycles in %s", limit, name));
    endtask

    task automatic run_update(input string name);
        bit seen;
        wait_for_update(name, seen);
        if (seen) begin
            model_update();
            update_total++;
            for (int c = 0; c < CHANNELS; c++) begin
                last_out[c] = ctrl_channel(c);
                check_sample($sformatf("%s ch%0d", name, c), u_exp[c], last_out[c]);
            end
        end
    endtask

    task automatic write_read_check(input string name, input apb_addr_t addr,
                                    input apb_word_t value, input apb_word_t expected);
        apb_word_t rd;
        apb_write(addr, value);
        apb_read(addr, rd);
        check_word(name, expected, rd);
    endtask

    task automatic test_readback();
        apb_word_t v;
        apb_word_t rd;
        apb_addr_t hole;
        v = $urandom() | 32'h0000_0400;  // long period, no trigger during the ctrl check
        write_read_check("period", REG_PERIOD, v, v & 32'h0000_ffff);
        v = $urandom();
        write_read_check("kp", REG_KP, v, v & 32'h0000_ffff);
        v = $urandom();
        write_read_check("ki", REG_KI, v, v & 32'h0000_ffff);
        v = $urandom();
        write_read_check("ref0", REG_REF0, v, apb_word_t'(int'(sample_t'(v[DATA_WIDTH-1:0]))));
        v = $urandom();
        write_read_check("ref1", REG_REF1, v, apb_word_t'(int'(sample_t'(v[DATA_WIDTH-1:0]))));
        v = $urandom();
        write_read_check("ctrl", REG_CTRL, v, {31'd0, v[0]});
        apb_write(REG_CTRL, 32'd0);
        hole = apb_addr_t'(32'h24 + 4 * $urandom_range(50, 0));
        apb_read(hole, rd);
        check_word("unmapped read", 32'd0, rd);
        apb_write(REG_OUT0, $urandom());
        apb_read(REG_OUT0, rd);
        check_word("out0 after write", 32'd0, rd);
        test_done("readback");
    endtask

    task automatic test_single_update();
        for (int c = 0; c < CHANNELS; c++) begin
            ref_m[c]    = random_sample(1000);
            e_prev_m[c] = 0;
            u_prev_m[c] = 0;
        end
        kp_m     = longint'($urandom_range(32767, 0));
        ki_m     = longint'($urandom_range(8191, 0));
        period_m = 2 * CALC_CYCLES + 20 + int'($urandom_range(40, 0));
        set_sensors(random_sample(1000), random_sample(1000));
        apb_write(REG_KP, apb_word_t'(kp_m));
        apb_write(REG_KI, apb_word_t'(ki_m));
        apb_write(REG_REF0, apb_word_t'(ref_m[0]));
        apb_write(REG_REF1, apb_word_t'(ref_m[1]));
        apb_write(REG_PERIOD, apb_word_t'(period_m));
        apb_write(REG_CTRL, 32'd1);
        run_update("single");
        test_done("single_update");
    endtask

    task automatic test_sequence();
        for (int i = 0; i < 30; i++) begin
            set_sensors(random_sample(1000), random_sample(1000));
            run_update($sformatf("sequence %0d", i));
        end
        test_done("sequence");
    endtask

    task automatic test_saturation();
        kp_m     = 4096;   // 1/16
        ki_m     = 32768;  // 1/2
        ref_m[0] = 4000;
        ref_m[1] = -4000;
        apb_write(REG_KP, apb_word_t'(kp_m));
        apb_write(REG_KI, apb_word_t'(ki_m));
        apb_write(REG_REF0, apb_word_t'(ref_m[0]));
        apb_write(REG_REF1, apb_word_t'(ref_m[1]));
        set_sensors(-16'sd4000, 16'sd4000);
        for (int i = 0; i < 3; i++)
            run_update($sformatf("saturate %0d", i));
        check_sample("ch0 at upper limit", sample_t'(DATA_LIMIT), last_out[0]);
        check_sample("ch1 at lower limit", sample_t'(-DATA_LIMIT), last_out[1]);
        set_sensors(16'sd5000, -16'sd5000);  // error changes sign
        run_update("reversal");
        if (last_out[0] >= DATA_LIMIT || last_out[1] <= -DATA_LIMIT)
            note_failure("output stayed at the limit after the error reversed");
        test_done("saturation");
    endtask

    task automatic test_status();
        apb_word_t rd;
        apb_read(REG_OUT0, rd);
        check_word("out0 readback", apb_word_t'(int'(u_exp[0])), rd);
        apb_read(REG_OUT1, rd);
        check_word("out1 readback", apb_word_t'(int'(u_exp[1])), rd);
        apb_read(REG_COUNT, rd);
        check_word("update count", apb_word_t'(update_total), rd);
        test_done("status");
    endtask

    task automatic test_disable();
        apb_word_t rd;
        int        window;
        bit        seen;
        apb_write(REG_CTRL, 32'd0);
        window = 4 * (period_m + 1);
        seen   = 1'b0;
        for (int n = 0; n < window; n++) begin
            @(posedge clk);
            if (ctrl_valid)
                seen = 1'b1;
        end
        if (seen)
            note_failure("ctrl_valid appeared while the regulator was disabled");
        apb_read(REG_COUNT, rd);
        check_word("count after disable", apb_word_t'(update_total), rd);
        test_done("disable");
    endtask

    initial begin
        void'($urandom(32'h5a5d));
        clk               = 1'b0;
        reset             = 1'b1;
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        paddr             = '0;
        pwdata            = '0;
        sensor_data       = '0;
        sensor_valid      = 1'b0;
        pass_count        = 0;
        fail_count        = 0;
        fails_before_test = 0;
        update_total      = 0;
        period_m          = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        test_readback();
        test_single_update();
        test_sequence();
        test_saturation();
        test_status();
        test_disable();

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- pi_ctrl_top.f
pi_ctrl_pkg.sv
pi_apb_regs.sv
pi_sample_timer.sv
pi_controller.sv
pi_ctrl_top.sv
tb_pi_ctrl_top.sv

//--- Makefile
# Verilator run of the two-channel PI regulator testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log and check it"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_pi_ctrl_top -f pi_ctrl_top.f
	./obj_dir/Vtb_pi_ctrl_top | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
